// ==== hdl/des_cfg.svh ====
`ifndef DES_CFG_SVH
`define DES_CFG_SVH

// rounds applied by the iterative core.
`define DES_ROUNDS 16

// request buffer entries, equal to the upstream's starting credits.
`define DES_REQ_DEPTH 4

// responses the core may send before the downstream returns a credit.
`define DES_RSP_CREDITS 2

`endif

// ==== hdl/des_pkg.sv ====
package des_pkg;

	// one 64-bit data block, bit 63 is DES bit 1.
	typedef logic [63:0] des_block_t;

	// key with parity bits still in place.
	typedef logic [63:0] des_key_t;

	// L or R half of the Feistel state.
	typedef logic [31:0] des_half_t;

	// C or D half of the key schedule.
	typedef logic [27:0] des_cd_t;

	typedef logic [47:0] des_subkey_t;

	typedef struct packed {
		des_block_t block;
		des_key_t   key;
		logic       decrypt;
	} des_req_t;

	// decrypt is echoed from the request.
	typedef struct packed {
		des_block_t block;
		logic       decrypt;
	} des_rsp_t;

endpackage

// ==== hdl/des_req_fifo.sv ====
`include "des_cfg.svh"

module des_req_fifo (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              push,
	input  des_pkg::des_req_t push_data,
	input  logic              pop,
	output des_pkg::des_req_t pop_data,
	output logic              not_empty,
	output logic              credit
);
	localparam int AW = $clog2(`DES_REQ_DEPTH);
	localparam int CW = $clog2(`DES_REQ_DEPTH + 1);

	des_pkg::des_req_t mem [`DES_REQ_DEPTH];
	logic [AW-1:0]     wr_ptr_q;
	logic [AW-1:0]     rd_ptr_q;
	logic [CW-1:0]     count_q;
	logic              do_pop;

	assign not_empty = (count_q != '0);
	assign do_pop    = pop && not_empty;
	assign pop_data  = mem[rd_ptr_q];

	// each released slot goes back to the upstream as one credit.
	assign credit = do_pop;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr_q] <= push_data;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= (wr_ptr_q == AW'(`DES_REQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= (rd_ptr_q == AW'(`DES_REQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			if (push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (!push && do_pop)
				count_q <= count_q - 1'b1;
		end
	end

endmodule

// ==== hdl/des_key_schedule.sv ====
`include "des_cfg.svh"

module des_key_schedule (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          key_load,
	input  des_pkg::des_key_t             key,
	input  logic                          decrypt,
	input  logic [$clog2(`DES_ROUNDS)-1:0] round,
	output des_pkg::des_subkey_t          subkey
);
	localparam int PC1 [56] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};

	localparam int PC2 [48] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	// left shift per encryption round.
	localparam int SHIFT [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	des_pkg::des_cd_t c_q;
	des_pkg::des_cd_t d_q;
	des_pkg::des_cd_t cur_c;
	des_pkg::des_cd_t cur_d;
	logic             dec_q;
	logic [55:0]      cd_init;
	logic [55:0]      cd_cur;

	function automatic des_pkg::des_cd_t rot_left(input des_pkg::des_cd_t x, input int n);
		return des_pkg::des_cd_t'((x << n) | (x >> (28 - n)));
	endfunction

	function automatic des_pkg::des_cd_t rot_right(input des_pkg::des_cd_t x, input int n);
		return des_pkg::des_cd_t'((x >> n) | (x << (28 - n)));
	endfunction

	always_comb
	begin
		for (int i = 0; i < 56; i++)
			cd_init[55 - i] = key[64 - PC1[i]];
	end

	// decryption walks the encryption rotations backwards, starting unrotated.
	always_comb
	begin
		if (!dec_q)
		begin
			cur_c = rot_left(c_q, SHIFT[round]);
			cur_d = rot_left(d_q, SHIFT[round]);
		end
		else if (round == '0)
		begin
			cur_c = c_q;
			cur_d = d_q;
		end
		else
		begin
			cur_c = rot_right(c_q, SHIFT[`DES_ROUNDS - round]);
			cur_d = rot_right(d_q, SHIFT[`DES_ROUNDS - round]);
		end
	end

	assign cd_cur = {cur_c, cur_d};

	always_comb
	begin
		for (int i = 0; i < 48; i++)
			subkey[47 - i] = cd_cur[56 - PC2[i]];
	end

	always_ff @(posedge clk)
	begin
		if (key_load)
			{c_q, d_q} <= cd_init;
		else
			{c_q, d_q} <= {cur_c, cur_d};
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			dec_q <= 1'b0;
		else if (key_load)
			dec_q <= decrypt;
	end

endmodule

// ==== hdl/des_feistel.sv ====
module des_feistel (
	input  des_pkg::des_half_t   r,
	input  des_pkg::des_subkey_t subkey,
	output des_pkg::des_half_t   f
);
	localparam int E_TAB [48] = '{
		32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
	};

	localparam int P_TAB [32] = '{
		16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
	};

	// rows of sixteen, indexed by {b1, b6, b2..b5}.
	localparam logic [3:0] SBOX [8][64] = '{
		'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
		   0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
		   4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
		  15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
		'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
		   3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
		   0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
		  13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
		'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
		  13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
		  13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
		   1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
		'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
		  13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
		  10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
		   3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
		'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
		  14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
		   4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
		  11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
		'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
		  10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
		   9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
		   4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
		'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
		  13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
		   1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
		   6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
		'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
		   1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
		   7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
		   2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
	};

	des_pkg::des_subkey_t expanded;
	des_pkg::des_subkey_t mixed;
	des_pkg::des_half_t   sbox_out;

	always_comb
	begin
		for (int i = 0; i < 48; i++)
			expanded[47 - i] = r[32 - E_TAB[i]];
	end

	assign mixed = expanded ^ subkey;

	// outer bits pick the row, inner four the column.
	always_comb
	begin
		for (int s = 0; s < 8; s++)
			sbox_out[31 - 4*s -: 4] = SBOX[s][{mixed[47 - 6*s], mixed[42 - 6*s],
				mixed[46 - 6*s -: 4]}];
	end

	always_comb
	begin
		for (int i = 0; i < 32; i++)
			f[31 - i] = sbox_out[32 - P_TAB[i]];
	end

endmodule

// ==== hdl/des_core.sv ====
`include "des_cfg.svh"

module des_core (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           not_empty,
	output logic                           pop,
	input  des_pkg::des_req_t              req,
	output logic                           key_load,
	output des_pkg::des_key_t              key,
	output logic                           decrypt,
	output logic [$clog2(`DES_ROUNDS)-1:0] round,
	input  des_pkg::des_half_t             f,
	output des_pkg::des_half_t             r_half,
	input  des_pkg::des_subkey_t           subkey,
	output des_pkg::des_subkey_t           f_subkey,
	output logic                           rsp_valid,
	output des_pkg::des_rsp_t              rsp,
	input  logic                           rsp_credit
);
	localparam int RW = $clog2(`DES_ROUNDS);
	localparam int CW = $clog2(`DES_RSP_CREDITS + 1);

	localparam int IP_TAB [64] = '{
		58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
		62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
		57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
		61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
	};

	localparam int FP_TAB [64] = '{
		40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
		38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
		36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
		34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
	};

	typedef enum logic [1:0] {
		IDLE,
		ROUNDS,
		HOLD
	} state_t;

	state_t              state_q;
	logic [RW-1:0]       round_q;
	logic [CW-1:0]       credit_q;
	des_pkg::des_half_t  l_q;
	des_pkg::des_half_t  r_q;
	des_pkg::des_rsp_t   rsp_q;
	des_pkg::des_block_t ip_block;
	des_pkg::des_block_t fp_block;

	function automatic des_pkg::des_block_t permute(input des_pkg::des_block_t x,
		input int tab [64]);
		des_pkg::des_block_t o;
		for (int i = 0; i < 64; i++)
			o[63 - i] = x[64 - tab[i]];
		return o;
	endfunction

	assign ip_block = permute(req.block, IP_TAB);

	// halves are swapped ahead of FP after the last round.
	assign fp_block = permute({l_q ^ f, r_q}, FP_TAB);

	assign pop       = (state_q == IDLE) && not_empty;
	assign key_load  = pop;
	assign key       = req.key;
	assign decrypt   = req.decrypt;
	assign round     = round_q;
	assign rsp_valid = (state_q == HOLD) && (credit_q != '0);
	assign rsp       = rsp_q;

	// feistel operands stay quiet outside the rounds.
	assign r_half   = (state_q == ROUNDS) ? r_q : '0;
	assign f_subkey = (state_q == ROUNDS) ? subkey : '0;

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			{l_q, r_q}    <= ip_block;
			rsp_q.decrypt <= req.decrypt;
		end
		else if (state_q == ROUNDS)
		begin
			l_q <= r_q;
			r_q <= l_q ^ f;
			if (round_q == RW'(`DES_ROUNDS - 1))
				rsp_q.block <= fp_block;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q  <= IDLE;
			round_q  <= '0;
			credit_q <= CW'(`DES_RSP_CREDITS);
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					round_q <= '0;
					if (pop)
						state_q <= ROUNDS;
				end
				ROUNDS:
				begin
					round_q <= round_q + 1'b1;
					if (round_q == RW'(`DES_ROUNDS - 1))
						state_q <= HOLD;
				end
				default:
				begin
					if (rsp_valid)
						state_q <= IDLE;
				end
			endcase
			if (rsp_credit && !rsp_valid)
				credit_q <= credit_q + 1'b1;
			else if (!rsp_credit && rsp_valid)
				credit_q <= credit_q - 1'b1;
		end
	end

endmodule

// ==== hdl/des_top.sv ====
`include "des_cfg.svh"

module des_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req_valid,
	input  des_pkg::des_req_t req,
	output logic              req_credit,
	output logic              rsp_valid,
	output des_pkg::des_rsp_t rsp,
	input  logic              rsp_credit
);
	des_pkg::des_req_t              head;
	logic                           head_valid;
	logic                           pop;
	logic                           key_load;
	des_pkg::des_key_t              key;
	logic                           decrypt;
	logic [$clog2(`DES_ROUNDS)-1:0] round;
	des_pkg::des_subkey_t           subkey;
	des_pkg::des_subkey_t           f_subkey;
	des_pkg::des_half_t             r_half;
	des_pkg::des_half_t             f;

	des_req_fifo u_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (req_valid),
		.push_data (req),
		.pop       (pop),
		.pop_data  (head),
		.not_empty (head_valid),
		.credit    (req_credit)
	);

	des_core u_core (
		.clk        (clk),
		.arst_n     (arst_n),
		.not_empty  (head_valid),
		.pop        (pop),
		.req        (head),
		.key_load   (key_load),
		.key        (key),
		.decrypt    (decrypt),
		.round      (round),
		.f          (f),
		.r_half     (r_half),
		.subkey     (subkey),
		.f_subkey   (f_subkey),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit)
	);

	des_key_schedule u_key_schedule (
		.clk      (clk),
		.arst_n   (arst_n),
		.key_load (key_load),
		.key      (key),
		.decrypt  (decrypt),
		.round    (round),
		.subkey   (subkey)
	);

	des_feistel u_feistel (
		.r      (r_half),
		.subkey (f_subkey),
		.f      (f)
	);

endmodule

// ==== verification/des_vectors.svh ====
`ifndef DES_VECTORS_SVH
`define DES_VECTORS_SVH

// columns: block, key, decrypt flag, expected result block.
// the decrypt rows undo the encrypt rows with the same key.
typedef struct packed {
	des_pkg::des_req_t   req;
	des_pkg::des_block_t expect_block;
} vector_t;

localparam int NUM_VECTORS = 4;

localparam vector_t VECTORS [NUM_VECTORS] = '{
	'{'{64'h0123456789abcdef, 64'h133457799bbcdff1, 1'b0}, 64'h85e813540f0ab405},
	'{'{64'h8787878787878787, 64'h0e329232ea6d0d73, 1'b0}, 64'h0000000000000000},
	'{'{64'h85e813540f0ab405, 64'h133457799bbcdff1, 1'b1}, 64'h0123456789abcdef},
	'{'{64'h0000000000000000, 64'h0e329232ea6d0d73, 1'b1}, 64'h8787878787878787}
};

`endif

// ==== verification/des_tb.sv ====
`include "des_cfg.svh"

module des_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 2000;
	localparam int TRIPS = 10;

	// enough to fill the sent credits, the held result and the whole buffer.
	localparam int FLOOD = `DES_REQ_DEPTH + `DES_RSP_CREDITS + 1;

	`include "des_vectors.svh"

	logic              clk;
	logic              arst_n;
	logic              req_valid;
	des_pkg::des_req_t req;
	logic              req_credit;
	logic              rsp_valid;
	des_pkg::des_rsp_t rsp;
	logic              rsp_credit;

	int                seed;
	int                errors;
	int                checks;
	int                test_errors;
	int                sent_cnt;
	int                ret_cnt;
	int                rsp_count;
	int                credits_ret;
	int                delay_cnt;
	int                credit_delay;
	logic              withhold;
	des_pkg::des_rsp_t rsp_log [$];

	des_top i_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// outputs are sampled mid-cycle, away from the driving edge.
	always @(negedge clk)
	begin
		if (arst_n && req_credit)
			ret_cnt++;
		if (arst_n && rsp_valid)
		begin
			rsp_log.push_back(rsp);
			rsp_count++;
		end
	end

	// downstream returns one credit per consumed response.
	always @(posedge clk)
	begin
		rsp_credit <= 1'b0;
		if (!withhold && (rsp_count > credits_ret))
		begin
			if (delay_cnt >= credit_delay)
			begin
				rsp_credit  <= 1'b1;
				credits_ret <= credits_ret + 1;
				delay_cnt   <= 0;
			end
			else
				delay_cnt <= delay_cnt + 1;
		end
	end

	task automatic abort_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_rsp(input des_pkg::des_rsp_t got, input des_pkg::des_rsp_t exp,
		input string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_credits(input int got, input int exp, input string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		if (errors == test_errors)
			$display("[test] %s: passed", name);
		else
			$display("[test] %s: failed with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// sends only while a credit is held, consecutive calls go back to back.
	task automatic send_req(input des_pkg::des_req_t r);
		int waited;
		waited = 0;
		@(posedge clk);
		while (`DES_REQ_DEPTH - sent_cnt + ret_cnt <= 0)
		begin
			req_valid <= 1'b0;
			if (waited >= WAIT_LIMIT)
				abort_on_timeout("a request credit");
			waited++;
			@(posedge clk);
		end
		req_valid <= 1'b1;
		req       <= r;
		sent_cnt++;
	endtask

	task automatic end_burst();
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic get_rsp(output des_pkg::des_rsp_t r);
		int waited;
		waited = 0;
		@(posedge clk);
		while (rsp_log.size() == 0)
		begin
			if (waited >= WAIT_LIMIT)
				abort_on_timeout("a response");
			waited++;
			@(posedge clk);
		end
		r = rsp_log.pop_front();
	endtask

	task automatic expect_rsp(input des_pkg::des_block_t block, input logic dec,
		input string name);
		des_pkg::des_rsp_t got;
		des_pkg::des_rsp_t exp;
		get_rsp(got);
		exp.block   = block;
		exp.decrypt = dec;
		check_rsp(got, exp, name);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(posedge clk);
		while (ret_cnt != sent_cnt || credits_ret != rsp_count)
		begin
			if (waited >= WAIT_LIMIT)
				abort_on_timeout("the credits to drain");
			waited++;
			@(posedge clk);
		end
	endtask

	task automatic run_table(input logic dec);
		for (int i = 0; i < NUM_VECTORS; i++)
		begin
			if (VECTORS[i].req.decrypt == dec)
			begin
				send_req(VECTORS[i].req);
				end_burst();
				expect_rsp(VECTORS[i].expect_block, dec, $sformatf("rsp (vector %0d)", i));
			end
		end
	endtask

	initial
	begin
		des_pkg::des_req_t   trip_req;
		des_pkg::des_rsp_t   got;
		des_pkg::des_block_t plain;
		int                  rsp_before;
		int                  ret_before;
		seed         = 32'hf5cc;
		errors       = 0;
		checks       = 0;
		test_errors  = 0;
		sent_cnt     = 0;
		ret_cnt      = 0;
		rsp_count    = 0;
		credits_ret  = 0;
		delay_cnt    = 0;
		credit_delay = 0;
		withhold     = 1'b0;
		arst_n       = 1'b0;
		req_valid    = 1'b0;
		req          = '0;
		rsp_credit   = 1'b0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag(req_credit, 1'b0, "req_credit");
		check_flag(rsp_valid, 1'b0, "rsp_valid");
		report_test("reset state");

		run_table(1'b0);
		report_test("known encryptions");
		run_table(1'b1);
		report_test("known decryptions");

		for (int i = 0; i < TRIPS; i++)
		begin
			plain            = {$random(seed), $random(seed)};
			trip_req.key     = {$random(seed), $random(seed)};
			trip_req.block   = plain;
			trip_req.decrypt = 1'b0;
			credit_delay    <= $unsigned($random(seed)) % 6;
			send_req(trip_req);
			end_burst();
			get_rsp(got);
			check_flag(got.decrypt, 1'b0, "rsp.decrypt");
			trip_req.block   = got.block;
			trip_req.decrypt = 1'b1;
			send_req(trip_req);
			end_burst();
			expect_rsp(plain, 1'b1, $sformatf("rsp (trip %0d)", i));
		end
		report_test("round trip");

		credit_delay <= 0;
		for (int i = 0; i < `DES_REQ_DEPTH; i++)
			send_req(VECTORS[i % NUM_VECTORS].req);
		end_burst();
		for (int i = 0; i < `DES_REQ_DEPTH; i++)
			expect_rsp(VECTORS[i % NUM_VECTORS].expect_block,
				VECTORS[i % NUM_VECTORS].req.decrypt, $sformatf("rsp (burst %0d)", i));
		report_test("ordering");

		wait_drain();
		withhold  <= 1'b1;
		rsp_before = rsp_count;
		for (int i = 0; i < FLOOD; i++)
			send_req(VECTORS[i % NUM_VECTORS].req);
		end_burst();
		ret_before = ret_cnt;
		// the core holds one result and the buffer is full, so nothing may move.
		repeat (2 * `DES_ROUNDS + 8) @(posedge clk);
		check_credits(rsp_count - rsp_before, `DES_RSP_CREDITS, "rsp_valid count");
		check_credits(ret_cnt - ret_before, 0, "req_credit count");
		check_credits(`DES_REQ_DEPTH - sent_cnt + ret_cnt, 0, "upstream credits");
		withhold <= 1'b0;
		for (int i = 0; i < FLOOD; i++)
			expect_rsp(VECTORS[i % NUM_VECTORS].expect_block,
				VECTORS[i % NUM_VECTORS].req.decrypt, $sformatf("rsp (flood %0d)", i));
		report_test("back-pressure");

		// every entry was popped before its response left.
		check_credits(`DES_REQ_DEPTH - sent_cnt + ret_cnt, `DES_REQ_DEPTH, "upstream credits");
		wait_drain();
		check_credits(rsp_count, sent_cnt, "rsp_valid count");
		report_test("credit conservation");

		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+hdl
+incdir+verification
hdl/des_pkg.sv
hdl/des_req_fifo.sv
hdl/des_key_schedule.sv
hdl/des_feistel.sv
hdl/des_core.sv
hdl/des_top.sv
verification/des_tb.sv

// ==== Bender.yml ====
package:
  name: des_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/des_pkg.sv
      - hdl/des_req_fifo.sv
      - hdl/des_key_schedule.sv
      - hdl/des_feistel.sv
      - hdl/des_core.sv
      - hdl/des_top.sv
  - target: test
    include_dirs:
      - hdl
      - verification
    files:
      - verification/des_tb.sv
